/* pwmTimerSys.f */
verilog/pwmPkg.sv
verilog/wbTimerBridge.sv
verilog/pwmTimer16.sv
verilog/intrCtrl.sv
verilog/pwmTimerSys.sv
sim/pwmTimerSys_props.sv
sim/pwmTimerSys_tb.sv

/* sim/pwmTimerSys_golden.txt */
# name op a b c : WR adr dat 0, RD adr expect 0, PER timer cycles 0, IRQ level 0 0
# DUTY timer window highCycles, WAIT cycles 0 0; all values hex
rst_irq   IRQ  0 0000 0000
val_wr    WR   0 1234 0000
val_rd    RD   0 1234 0000
max_wr    WR   2 00ff 0000
max_rd    RD   2 00ff 0000
cmp_wr    WR   3 0080 0000
cmp_rd    RD   3 0080 0000
ctl_wr    WR   5 ffff 0000
ctl_rd    RD   5 00f1 0000
ctl_off   WR   5 0000 0000
unmap_c   RD   c 0000 0000
unmap_f   RD   f 0000 0000
val_hold  RD   0 1234 0000
p0_max    WR   2 0009 0000
p0_cmp    WR   3 0000 0000
p0_val    WR   0 0000 0000
p0_mask   WR   9 0001 0000
p0_en     WR   1 0001 0000
p0_per    PER  0 000a 0000
p0_duty   DUTY 0 000a 000a
p0_cmp4   WR   3 0004 0000
p0_duty4  DUTY 0 000a 0006
p0_cmpbig WR   3 000a 0000
p0_dutylo DUTY 0 000a 0000
p3_off    WR   1 0000 0000
p3_val    WR   0 0000 0000
p3_max    WR   2 0004 0000
p3_cmp    WR   3 0002 0000
p3_en     WR   1 0031 0000
p3_per    PER  0 0014 0000
p3_duty   DUTY 0 0014 000c
t1_off0   WR   1 0000 0000
t1_max    WR   6 0007 0000
t1_cmp    WR   7 0003 0000
t1_mask   WR   9 0002 0000
t1_en     WR   5 0011 0000
t1_per    PER  1 0010 0000
t1_duty   DUTY 1 0010 000a
t1p2_max  WR   6 000b 0000
t1p2_en   WR   5 0021 0000
t1p2_per  PER  1 0024 0000
t1p2_duty DUTY 1 0024 001b
irq_mask0 WR   9 0000 0000
irq_clr   WR   8 0003 0000
irq_wait  WAIT 30 0000 0000
irq_low   IRQ  0 0000 0000
irq_stop  WR   5 0000 0000
pend_rd   RD   8 0002 0000
irq_mask1 WR   9 0002 0000
irq_high  IRQ  1 0000 0000
mask_rd   RD   9 0002 0000
pend_clr0 WR   8 0001 0000
pend_keep RD   8 0002 0000
pend_clr1 WR   8 0002 0000
pend_none RD   8 0000 0000
irq_drop  IRQ  0 0000 0000

/* sim/pwmTimerSys_tb.sv */
`timescale 1ns/1ns

module pwmTimerSys_tb;

  localparam int NumTimers = 2;
  localparam int MaxCycles = 40000;  // Golden periods summed with wide margin

  logic                 clk = 1'b0;
  logic                 rstN;
  pwmPkg::wbReqT        wbReq;
  pwmPkg::wbRspT        wbRsp;
  logic [NumTimers-1:0] pwmOut;
  logic                 irq;
  int                   cycles = 0;  // Timestamp for period checks

  pwmTimerSys #(.NumTimers(NumTimers)) u_dut (
    .clk    (clk),
    .rstN   (rstN),
    .wbReq  (wbReq),
    .wbRsp  (wbRsp),
    .pwmOut (pwmOut),
    .irq    (irq)
  );

  always #10 clk = ~clk;  // 20 ns

  //////////////////////////////
  // Timeout
  //////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles, a bus ack or an irq never arrived", cycles);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  task automatic checkValue(input logic [8*16-1:0] name, input int expected, input int actual);
    if (expected != actual) begin
      $display("ERROR %0s: expected %0h, actual %0h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // One Wishbone classic cycle held until ack
  task automatic busAccess(input logic we, input logic [3:0] adr, input logic [15:0] dat,
                           output logic [15:0] rd);
    @(posedge clk);
    #2;
    wbReq.cyc = 1'b1;
    wbReq.stb = 1'b1;
    wbReq.we  = we;
    wbReq.adr = adr;
    wbReq.dat = dat;
    @(negedge clk);
    while (!wbRsp.ack) @(negedge clk);
    rd = wbRsp.dat;  // Valid with ack
    @(posedge clk);
    #2;
    wbReq = '0;
  endtask

  task automatic waitIrqHigh();
    @(negedge clk);
    while (!irq) @(negedge clk);
  endtask

  task automatic clearPend(input logic [15:0] timer);
    logic [15:0] rd;
    busAccess(1'b1, 4'h8, 16'd1 << timer, rd);  // PEND is write 1 to clear
  endtask

  //////////////////////////////
  // Golden command loop
  //////////////////////////////

  initial begin
    int               fd;
    int               n;
    int               t0;
    int               hi;
    logic [8*16-1:0]  testName;
    logic [8*4-1:0]   op;
    logic [15:0]      a;
    logic [15:0]      b;
    logic [15:0]      c;
    logic [15:0]      rd;
    logic [8*256-1:0] rest;
    wbReq = '0;
    rstN  = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
    fd = $fopen("sim/pwmTimerSys_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden command file");
      $display("Simulation failed");
      $fatal(1);
    end
    while ($fscanf(fd, "%s", testName) == 1) begin
      if (testName == "#") begin
        n = $fgets(rest, fd);  // Column note skipped
      end else begin
        n = $fscanf(fd, "%s %h %h %h", op, a, b, c);
        if (n != 4) begin
          $display("Malformed command line in the golden file at %0s", testName);
          $display("Simulation failed");
          $fatal(1);
        end
        case (op)
          "WR": busAccess(1'b1, a[3:0], b, rd);
          "RD": begin
            busAccess(1'b0, a[3:0], 16'h0, rd);
            checkValue(testName, b, rd);
          end
          "PER": begin  // Irq rise to irq rise with PEND cleared between
            waitIrqHigh();
            clearPend(a);
            waitIrqHigh();
            t0 = cycles;
            clearPend(a);
            waitIrqHigh();
            checkValue(testName, b, cycles - t0);
          end
          "DUTY": begin
            hi = 0;
            repeat (b) begin
              @(negedge clk);
              if (pwmOut[a]) hi++;
            end
            checkValue(testName, c, hi);
          end
          "IRQ": begin
            @(negedge clk);
            checkValue(testName, a, irq);
          end
          "WAIT": repeat (a) @(posedge clk);
          default: begin
            $display("Unknown command %0s in the golden file at %0s", op, testName);
            $display("Simulation failed");
            $fatal(1);
          end
        endcase
      end
    end
    $fclose(fd);
    $display("Simulation passed");
    $finish;
  end

endmodule

/* sim/pwmTimerSys_props.sv */
`timescale 1ns/1ns

module pwmTimerSys_props (
  input logic          clk,
  input logic          rstN,
  input pwmPkg::wbReqT wbReq,
  input logic          ack,
  input logic          irq
);

  //////////////////////////////
  // Bus handshake
  //////////////////////////////

  // Ack only answers a request seen the cycle before
  ackFollowsReq: assert property (@(posedge clk) disable iff (!rstN)
    ack |-> $past(wbReq.cyc && wbReq.stb))
    else $error("ack without cyc and stb in the previous cycle");

  ackSingle: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
    else $error("ack high for two cycles in a row");  // Classic single-cycle ack

  // Registered outputs clear in the cycle after reset
  resetClears: assert property (@(posedge clk) !rstN |=> !ack && !irq)
    else $error("ack or irq high in the cycle after reset");

endmodule

// Handshake on the bridge
bind wbTimerBridge pwmTimerSys_props u_props (
  .clk   (clk),
  .rstN  (rstN),
  .wbReq (wbReq),
  .ack   (wbRsp.ack),
  .irq   (1'b0)
);

// Reset level of irq
bind intrCtrl pwmTimerSys_props u_props (
  .clk   (clk),
  .rstN  (rstN),
  .wbReq ('0),
  .ack   (1'b0),
  .irq   (irq)
);

/* verilog/pwmTimerSys.sv */
`timescale 1ns/1ns

module pwmTimerSys #(
  parameter int NumTimers = 2  // Unit field is 2 bits, so at most 3
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  pwmPkg::wbReqT        wbReq,
  output pwmPkg::wbRspT        wbRsp,
  output logic [NumTimers-1:0] pwmOut,
  output logic                 irq
);

  pwmPkg::regAccT             acc;      // Shared register access
  logic [NumTimers:0]         unitSel;
  logic [NumTimers-1:0][15:0] timerRd;
  logic [15:0]                intrRd;
  logic [NumTimers-1:0]       ovf;

  wbTimerBridge #(.NumTimers(NumTimers)) u_bridge (
    .clk     (clk),
    .rstN    (rstN),
    .wbReq   (wbReq),
    .wbRsp   (wbRsp),
    .acc     (acc),
    .unitSel (unitSel),
    .timerRd (timerRd),
    .intrRd  (intrRd)
  );

  // Timer channels, units 0 up
  for (genvar i = 0; i < NumTimers; i++) begin : gTimer
    pwmTimer16 u_timer (
      .clk    (clk),
      .rstN   (rstN),
      .acc    (acc),
      .sel    (unitSel[i]),
      .rdData (timerRd[i]),
      .ovf    (ovf[i]),
      .pwm    (pwmOut[i])
    );
  end

  intrCtrl #(.NumTimers(NumTimers)) u_intr (
    .clk    (clk),
    .rstN   (rstN),
    .acc    (acc),
    .sel    (unitSel[NumTimers]),  // Unit after the last timer
    .ovf    (ovf),
    .rdData (intrRd),
    .irq    (irq)
  );

endmodule

/* verilog/intrCtrl.sv */
`timescale 1ns/1ns

module intrCtrl #(
  parameter int NumTimers = 2
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  pwmPkg::regAccT       acc,
  input  logic                 sel,     // Controller addressed
  input  logic [NumTimers-1:0] ovf,     // Pulses from the timers
  output logic [15:0]          rdData,
  output logic                 irq
);

  logic [NumTimers-1:0] pendQ;   // Sticky overflow flags
  logic [NumTimers-1:0] maskQ;   // 1 enables the bit onto irq
  logic [NumTimers-1:0] clrBits;
  logic                 wrPend;
  logic                 wrMask;

  // PEND at offset 0, MASK at offset 1
  assign wrPend  = sel && acc.wr && (acc.sel == pwmPkg::regVal);
  assign wrMask  = sel && acc.wr && (acc.sel == pwmPkg::regCtl);
  assign clrBits = wrPend ? acc.dat[NumTimers-1:0] : '0;  // Write 1 to clear

  //////////////////////////////
  // Pending, mask, irq
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pendQ <= '0;
      maskQ <= '0;
      irq   <= 1'b0;
    end else begin
      pendQ <= (pendQ & ~clrBits) | ovf;  // New overflow wins over clear
      if (wrMask) begin
        maskQ <= acc.dat[NumTimers-1:0];
      end
      irq <= |(pendQ & maskQ);
    end
  end

  // Offsets 2 and 3 read 0
  always_comb begin
    rdData = '0;
    if (acc.sel == pwmPkg::regVal) begin
      rdData[NumTimers-1:0] = pendQ;
    end else if (acc.sel == pwmPkg::regCtl) begin
      rdData[NumTimers-1:0] = maskQ;
    end
  end

endmodule

/* verilog/pwmTimer16.sv */
`timescale 1ns/1ns

module pwmTimer16 (
  input  logic           clk,
  input  logic           rstN,
  input  pwmPkg::regAccT acc,
  input  logic           sel,     // This timer addressed
  output logic [15:0]    rdData,
  output logic           ovf,     // One-cycle wrap pulse
  output logic           pwm
);

  // Bus-visible registers
  logic [15:0] valQ;
  logic [15:0] maxQ;
  logic [15:0] cmpQ;
  logic        ctlEn;                    // CTL bit 0
  logic [pwmPkg::CtlPsW-1:0] ctlPs;      // CTL bits 7:4

  // Hidden state
  logic [pwmPkg::CtlPsW-1:0] psQ;        // Prescale counter

  logic        wrAny;
  logic        wrVal;
  logic        tick;
  logic        atMax;
  logic [15:0] ctlRd;

  assign wrAny = sel && acc.wr;
  assign wrVal = wrAny && (acc.sel == pwmPkg::regVal);
  assign tick  = ctlEn && (psQ == ctlPs);  // Every limit+1 cycles
  assign atMax = (valQ == maxQ);

  //////////////////////////////
  // Prescaler
  //////////////////////////////

  // Restarts on any write to this timer, held at 0 while disabled
  always_ff @(posedge clk) begin
    if (!rstN) begin
      psQ <= '0;
    end else if (wrAny || !ctlEn || tick) begin
      psQ <= '0;
    end else begin
      psQ <= psQ + 1'b1;
    end
  end

  //////////////////////////////
  // Registers and counter
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      valQ  <= '0;
      maxQ  <= '0;
      cmpQ  <= '0;
      ctlEn <= 1'b0;
      ctlPs <= '0;
    end else begin
      if (wrVal) begin
        valQ <= acc.dat;  // Bus write beats the increment
      end else if (tick) begin
        valQ <= atMax ? 16'd0 : valQ + 16'd1;
      end
      if (wrAny && acc.sel == pwmPkg::regCtl) begin
        ctlEn <= acc.dat[pwmPkg::CtlEnBit];
        ctlPs <= acc.dat[pwmPkg::CtlPsLsb +: pwmPkg::CtlPsW];
      end
      if (wrAny && acc.sel == pwmPkg::regMax) begin
        maxQ <= acc.dat;
      end
      if (wrAny && acc.sel == pwmPkg::regCmp) begin
        cmpQ <= acc.dat;
      end
    end
  end

  // Wrap pulse lines up with VAL reading 0
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ovf <= 1'b0;
      pwm <= 1'b0;
    end else begin
      ovf <= tick && atMax && !wrVal;
      pwm <= ctlEn && (valQ >= cmpQ);  // One cycle behind VAL
    end
  end

  //////////////////////////////
  // Readback
  //////////////////////////////

  always_comb begin
    ctlRd = '0;  // Unused CTL bits read 0
    ctlRd[pwmPkg::CtlEnBit] = ctlEn;
    ctlRd[pwmPkg::CtlPsLsb +: pwmPkg::CtlPsW] = ctlPs;
  end

  always_comb begin
    case (acc.sel)
      pwmPkg::regVal: rdData = valQ;
      pwmPkg::regCtl: rdData = ctlRd;
      pwmPkg::regMax: rdData = maxQ;
      default:        rdData = cmpQ;
    endcase
  end

endmodule

/* verilog/wbTimerBridge.sv */
`timescale 1ns/1ns

module wbTimerBridge #(
  parameter int NumTimers = 2  // Legal 1 to 3
) (
  input  logic                       clk,
  input  logic                       rstN,
  input  pwmPkg::wbReqT              wbReq,
  output pwmPkg::wbRspT              wbRsp,
  output pwmPkg::regAccT             acc,
  output logic [NumTimers:0]         unitSel,   // One-hot, top bit is intrCtrl
  input  logic [NumTimers-1:0][15:0] timerRd,
  input  logic [15:0]                intrRd
);

  pwmPkg::unitSelE unit;     // Decoded unit field
  logic            access;   // Qualified bus cycle
  logic            ackQ;
  logic [15:0]     rdMux;
  logic [15:0]     rdQ;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign unit   = pwmPkg::unitSelE'(wbReq.adr[3:2]);
  assign access = wbReq.cyc && wbReq.stb && !ackQ;  // Not in the ack cycle

  // Same access to every unit, select picks the target
  assign acc.wr  = access && wbReq.we;
  assign acc.sel = pwmPkg::regSelE'(wbReq.adr[1:0]);
  assign acc.dat = wbReq.dat;

  always_comb begin
    unitSel = '0;
    for (int i = 0; i < NumTimers; i++) begin
      unitSel[i] = access && (unit == pwmPkg::unitSelE'(i));
    end
    // Interrupt controller sits right after the last timer
    unitSel[NumTimers] = access && (unit == pwmPkg::unitSelE'(NumTimers));
  end

  //////////////////////////////
  // Read mux and response
  //////////////////////////////

  always_comb begin
    rdMux = '0;  // Unmapped units read 0
    for (int i = 0; i < NumTimers; i++) begin
      if (unit == pwmPkg::unitSelE'(i)) begin
        rdMux = timerRd[i];  // Unit already muxed on offset
      end
    end
    if (unit == pwmPkg::unitSelE'(NumTimers)) begin
      rdMux = intrRd;
    end
  end

  // Single-cycle ack, drops for one cycle between back-to-back accesses
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ackQ <= 1'b0;
    end else begin
      ackQ <= access;
    end
  end

  // Captured with the ack, held otherwise
  always_ff @(posedge clk) begin
    if (access) begin
      rdQ <= rdMux;  // Loads on writes too, master ignores it
    end
  end

  assign wbRsp.ack = ackQ;
  assign wbRsp.dat = rdQ;

endmodule

/* verilog/pwmPkg.sv */
package pwmPkg;

  //////////////////////////////
  // Wishbone bus
  //////////////////////////////

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;  // Word address, unit in [3:2]
    logic [15:0] dat;  // Write data
  } wbReqT;

  typedef struct packed {
    logic        ack;
    logic [15:0] dat;  // Read data
  } wbRspT;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Offset within a unit
  typedef enum logic [1:0] {
    regVal = 2'd0,  // PEND in intrCtrl
    regCtl = 2'd1,  // MASK in intrCtrl
    regMax = 2'd2,
    regCmp = 2'd3
  } regSelE;

  // Unit field, adr[3:2]
  typedef enum logic [1:0] {
    unit0 = 2'd0,
    unit1 = 2'd1,
    unit2 = 2'd2,
    unit3 = 2'd3
  } unitSelE;

  // One register access, bridge to all units
  typedef struct packed {
    logic        wr;   // Write strobe, already qualified
    regSelE      sel;  // Register offset
    logic [15:0] dat;
  } regAccT;

  // CTL layout
  localparam int CtlEnBit = 0;  // Timer enable
  localparam int CtlPsLsb = 4;  // Prescale limit low bit
  localparam int CtlPsW   = 4;  // Prescale limit width, bits 7:4

endpackage
